//--- design/mm_defs.svh
// size and width parameters of the matrix-multiply accelerator
// include ahead of any file that sizes ports or storage from these
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// PE array edge, so the result tile is 4x4
`define MM_SA_WIDTH 4

// one matrix element
`define MM_DW 32

// one buffer row, also one bus beat of four lanes
`define MM_BUF_DW 128

// buffer row address, 64 rows covers the largest K
`define MM_BUF_AW 6

// memory byte address
`define MM_ADDR_W 32

// full signed product plus one guard bit
`define MM_ACC_W (2 * `MM_DW + 1)

`endif

//--- design/mm_pkg.sv
// shared types of the accelerator: bus payloads, job settings, result tile
// and state encodings, referenced by scoped name from RTL and testbench
`include "mm_defs.svh"

package mm_pkg;

    // software register map
    typedef enum logic [2:0] {
        A_ADDR, B_ADDR, C_ADDR, WIDTH, CTRL, STATUS
    } cfg_reg_e;

    // one software access, write when wr is high
    typedef struct packed {
        logic        wr;
        cfg_reg_e    idx;
        logic [31:0] wdata;
    } cfg_req_t;

    // settings of one job, width is K
    typedef struct packed {
        logic [`MM_ADDR_W-1:0] a_addr;
        logic [`MM_ADDR_W-1:0] b_addr;
        logic [`MM_ADDR_W-1:0] c_addr;
        logic [7:0]            width;
    } mm_cfg_t;

    // AR and AW channel payload
    typedef struct packed {
        logic                  valid;
        logic [`MM_ADDR_W-1:0] addr;
    } axi_addr_t;

    // R and W channel payload
    typedef struct packed {
        logic                  valid;
        logic [`MM_BUF_DW-1:0] data;
    } axi_data_t;

    // tile buffer write port
    typedef struct packed {
        logic                  wren;
        logic [`MM_BUF_AW-1:0] waddr;
        logic [`MM_BUF_DW-1:0] wdata;
    } buf_wr_t;

    // accumulator (i,j) sits at index i*4+j
    typedef logic signed [`MM_ACC_W-1:0] acc_t;
    typedef acc_t [`MM_SA_WIDTH*`MM_SA_WIDTH-1:0] acc_tile_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, START_MM, WAIT_MM, WRITE_C, DRAIN_B
    } dma_state_e;

    typedef enum logic [1:0] {
        MM_IDLE, MM_RUN, MM_FLUSH
    } mm_state_e;

endpackage

//--- design/mm_cfg_regs.sv
// software-visible registers of the accelerator
// holds the job settings, launches the DMA and reports busy and done
module mm_cfg_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  mm_pkg::cfg_req_t  cfg_req_i,
    output logic [31:0]       cfg_rdata_o,
    input  logic              job_done_i,
    output logic              job_start_o,
    output mm_pkg::mm_cfg_t   cfg_o
);

    logic busy_q;
    logic done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_o       <= '0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            job_start_o <= 1'b0;
        end else begin
            // start is a single-cycle pulse
            job_start_o <= 1'b0;
            // job finished, done stays up until the next start
            if (job_done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (cfg_req_i.wr) begin
                case (cfg_req_i.idx)
                    mm_pkg::A_ADDR: cfg_o.a_addr <= cfg_req_i.wdata;
                    mm_pkg::B_ADDR: cfg_o.b_addr <= cfg_req_i.wdata;
                    mm_pkg::C_ADDR: cfg_o.c_addr <= cfg_req_i.wdata;
                    mm_pkg::WIDTH:  cfg_o.width  <= cfg_req_i.wdata[7:0];
                    mm_pkg::CTRL: begin
                        // a second start during a job is dropped
                        if (cfg_req_i.wdata[0] && !busy_q) begin
                            job_start_o <= 1'b1;
                            busy_q      <= 1'b1;
                            done_q      <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // read mux, combinational by index
    always_comb begin
        case (cfg_req_i.idx)
            mm_pkg::A_ADDR: cfg_rdata_o = cfg_o.a_addr;
            mm_pkg::B_ADDR: cfg_rdata_o = cfg_o.b_addr;
            mm_pkg::C_ADDR: cfg_rdata_o = cfg_o.c_addr;
            mm_pkg::WIDTH:  cfg_rdata_o = 32'(cfg_o.width);
            // bit 0 busy, bit 1 done
            mm_pkg::STATUS: cfg_rdata_o = {30'b0, done_q, busy_q};
            // CTRL is write-only
            default:        cfg_rdata_o = '0;
        endcase
    end

endmodule

//--- design/tile_buffer.sv
// one row buffer between the DMA and the multiply engine
// written by the DMA, read with one cycle of latency, used for A and B
`include "mm_defs.svh"

module tile_buffer (
    input  logic                  clk,
    input  mm_pkg::buf_wr_t       wr_i,
    input  logic [`MM_BUF_AW-1:0] raddr_i,
    output logic [`MM_BUF_DW-1:0] rdata_o
);

    // one row per k
    logic [`MM_BUF_DW-1:0] mem [2**`MM_BUF_AW];

    always_ff @(posedge clk) begin
        if (wr_i.wren) begin
            mem[wr_i.waddr] <= wr_i.wdata;
        end
        // registered read
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- design/mm_engine.sv
// multiply engine: walks the K buffered rows of A and B and accumulates
// all 16 products per row, done pulses K+2 cycles after start
`include "mm_defs.svh"

module mm_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [7:0]            width_i,
    output logic [`MM_BUF_AW-1:0] a_raddr_o,
    input  logic [`MM_BUF_DW-1:0] a_rdata_i,
    output logic [`MM_BUF_AW-1:0] b_raddr_o,
    input  logic [`MM_BUF_DW-1:0] b_rdata_i,
    output logic                  done_o,
    output mm_pkg::acc_tile_t     acc_o
);

    localparam int SA = `MM_SA_WIDTH;

    mm_pkg::mm_state_e     state_q;
    logic [`MM_BUF_AW-1:0] raddr_q;
    // read data of the previous RUN cycle is on the bus
    logic                  rd_vld_q;

    // A and B row k are read together
    assign a_raddr_o = raddr_q;
    assign b_raddr_o = raddr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= mm_pkg::MM_IDLE;
            raddr_q  <= '0;
            rd_vld_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            rd_vld_q <= (state_q == mm_pkg::MM_RUN);
            // last product goes in on the same edge
            done_o   <= (state_q == mm_pkg::MM_FLUSH);
            case (state_q)
                mm_pkg::MM_IDLE: begin
                    if (start_i) begin
                        state_q <= mm_pkg::MM_RUN;
                        raddr_q <= '0;
                    end
                end
                // rows 0 to K-1, one per cycle
                mm_pkg::MM_RUN: begin
                    raddr_q <= raddr_q + 1'b1;
                    if (8'(raddr_q) == width_i - 8'd1) begin
                        state_q <= mm_pkg::MM_FLUSH;
                    end
                end
                // covers the buffer read latency of row K-1
                mm_pkg::MM_FLUSH: state_q <= mm_pkg::MM_IDLE;
                default:          state_q <= mm_pkg::MM_IDLE;
            endcase
        end
    end

    // outer product of A column k and B row k, signed
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_o <= '0;
        end else if (rd_vld_q) begin
            for (int i = 0; i < SA; i++) begin
                for (int j = 0; j < SA; j++) begin
                    acc_o[i*SA + j] <= $signed(acc_o[i*SA + j])
                        + $signed(a_rdata_i[i*`MM_DW +: `MM_DW])
                        * $signed(b_rdata_i[j*`MM_DW +: `MM_DW]);
                end
            end
        end
    end

endmodule

//--- design/dma_engine.sv
// data mover of the accelerator: pulls K rows of A and B into the tile
// buffers, kicks the multiply engine, then writes the 4x4 tile back
`include "mm_defs.svh"

module dma_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  mm_pkg::mm_cfg_t    cfg_i,
    input  logic               start_i,
    output logic               done_o,
    output mm_pkg::axi_addr_t  ar_o,
    input  logic               ar_ready_i,
    input  mm_pkg::axi_data_t  r_i,
    output logic               r_ready_o,
    output mm_pkg::axi_addr_t  aw_o,
    input  logic               aw_ready_i,
    output mm_pkg::axi_data_t  w_o,
    input  logic               w_ready_i,
    input  logic               b_valid_i,
    output logic               b_ready_o,
    output mm_pkg::buf_wr_t    buf_a_wr_o,
    output mm_pkg::buf_wr_t    buf_b_wr_o,
    output logic               mm_start_o,
    input  logic               mm_done_i,
    input  mm_pkg::acc_tile_t  acc_tile_i
);

    localparam int SA    = `MM_SA_WIDTH;
    localparam int ROW_W = $clog2(SA);

    mm_pkg::dma_state_e    state_q;
    // issued and returned reads, counted over A then B
    logic [7:0]            ar_cnt_q;
    logic [7:0]            r_cnt_q;
    logic [7:0]            rows_total;
    logic [7:0]            ar_row;
    logic [7:0]            r_row;
    logic [ROW_W-1:0]      c_row_q;
    logic [ROW_W-1:0]      b_cnt_q;
    logic                  aw_pend_q;
    logic                  w_pend_q;
    logic                  a_wren_q;
    logic                  b_wren_q;
    logic [`MM_BUF_AW-1:0] buf_waddr_q;
    logic [`MM_BUF_DW-1:0] buf_wdata_q;
    logic [`MM_BUF_DW-1:0] c_row_data;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  b_hs;
    logic                  aw_clear;
    logic                  w_clear;

    // 2K reads per job, the first K from A
    assign rows_total = {cfg_i.width[6:0], 1'b0};
    assign ar_row     = (ar_cnt_q < cfg_i.width) ? ar_cnt_q : ar_cnt_q - cfg_i.width;
    assign r_row      = (r_cnt_q < cfg_i.width) ? r_cnt_q : r_cnt_q - cfg_i.width;

    // AR runs ahead of R, several reads may be in flight
    assign ar_o.valid = (state_q == mm_pkg::FETCH) && (ar_cnt_q < rows_total);
    assign ar_o.addr  = ((ar_cnt_q < cfg_i.width) ? cfg_i.a_addr : cfg_i.b_addr)
                      + {ar_row, 4'b0};
    assign ar_hs      = ar_o.valid && ar_ready_i;
    assign r_ready_o  = (state_q == mm_pkg::FETCH);
    assign r_hs       = r_i.valid && r_ready_o;
    assign b_ready_o  = (state_q == mm_pkg::WRITE_C) || (state_q == mm_pkg::DRAIN_B);
    assign b_hs       = b_valid_i && b_ready_o;
    assign mm_start_o = (state_q == mm_pkg::START_MM);

    // row i of C: low word of each accumulator, lane j at the low end
    always_comb begin
        for (int j = 0; j < SA; j++) begin
            c_row_data[j*`MM_DW +: `MM_DW] = acc_tile_i[c_row_q*SA + j][`MM_DW-1:0];
        end
    end

    assign aw_o     = '{valid: aw_pend_q, addr: cfg_i.c_addr + {c_row_q, 4'b0}};
    assign w_o      = '{valid: w_pend_q, data: c_row_data};
    // each channel is done once accepted now or earlier
    assign aw_clear = !aw_pend_q || aw_ready_i;
    assign w_clear  = !w_pend_q || w_ready_i;

    assign buf_a_wr_o = '{wren: a_wren_q, waddr: buf_waddr_q, wdata: buf_wdata_q};
    assign buf_b_wr_o = '{wren: b_wren_q, waddr: buf_waddr_q, wdata: buf_wdata_q};

    // returned beat lands in the buffer one cycle later
    always_ff @(posedge clk) begin
        buf_waddr_q <= r_row[`MM_BUF_AW-1:0];
        buf_wdata_q <= r_i.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= mm_pkg::IDLE;
            ar_cnt_q  <= '0;
            r_cnt_q   <= '0;
            c_row_q   <= '0;
            b_cnt_q   <= '0;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            a_wren_q  <= 1'b0;
            b_wren_q  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            a_wren_q <= r_hs && (r_cnt_q < cfg_i.width);
            b_wren_q <= r_hs && (r_cnt_q >= cfg_i.width);
            done_o   <= 1'b0;
            if (ar_hs) begin
                ar_cnt_q <= ar_cnt_q + 8'd1;
            end
            if (r_hs) begin
                r_cnt_q <= r_cnt_q + 8'd1;
            end
            if (b_hs) begin
                b_cnt_q <= b_cnt_q + 1'b1;
            end
            case (state_q)
                mm_pkg::IDLE: begin
                    if (start_i) begin
                        state_q  <= mm_pkg::FETCH;
                        ar_cnt_q <= '0;
                        r_cnt_q  <= '0;
                        b_cnt_q  <= '0;
                    end
                end
                // leave on the last returned beat
                mm_pkg::FETCH: begin
                    if (r_hs && (r_cnt_q == rows_total - 8'd1)) begin
                        state_q <= mm_pkg::START_MM;
                    end
                end
                mm_pkg::START_MM: state_q <= mm_pkg::WAIT_MM;
                mm_pkg::WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q   <= mm_pkg::WRITE_C;
                        c_row_q   <= '0;
                        aw_pend_q <= 1'b1;
                        w_pend_q  <= 1'b1;
                    end
                end
                mm_pkg::WRITE_C: begin
                    if (aw_ready_i) begin
                        aw_pend_q <= 1'b0;
                    end
                    if (w_ready_i) begin
                        w_pend_q <= 1'b0;
                    end
                    // next row only after both AW and W went out
                    if (aw_clear && w_clear) begin
                        if (c_row_q == ROW_W'(SA - 1)) begin
                            state_q <= mm_pkg::DRAIN_B;
                        end else begin
                            c_row_q   <= c_row_q + 1'b1;
                            aw_pend_q <= 1'b1;
                            w_pend_q  <= 1'b1;
                        end
                    end
                end
                // wait for the last write response
                mm_pkg::DRAIN_B: begin
                    if (b_hs && (b_cnt_q == ROW_W'(SA - 1))) begin
                        state_q <= mm_pkg::IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= mm_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- design/mm_accel_top.sv
// top of the matrix-multiply accelerator
// software register port on one side, single-beat AXI read and write on the other
`include "mm_defs.svh"

module mm_accel_top (
    input  logic               clk,
    input  logic               rst_n,
    input  mm_pkg::cfg_req_t   cfg_req_i,
    output logic [31:0]        cfg_rdata_o,
    output mm_pkg::axi_addr_t  ar_o,
    input  logic               ar_ready_i,
    input  mm_pkg::axi_data_t  r_i,
    output logic               r_ready_o,
    output mm_pkg::axi_addr_t  aw_o,
    input  logic               aw_ready_i,
    output mm_pkg::axi_data_t  w_o,
    input  logic               w_ready_i,
    input  logic               b_valid_i,
    output logic               b_ready_o
);

    mm_pkg::mm_cfg_t       cfg;
    logic                  job_start;
    logic                  job_done;
    logic                  mm_start;
    logic                  mm_done;
    mm_pkg::buf_wr_t       buf_a_wr;
    mm_pkg::buf_wr_t       buf_b_wr;
    logic [`MM_BUF_AW-1:0] a_raddr;
    logic [`MM_BUF_AW-1:0] b_raddr;
    logic [`MM_BUF_DW-1:0] a_rdata;
    logic [`MM_BUF_DW-1:0] b_rdata;
    mm_pkg::acc_tile_t     acc_tile;

    mm_cfg_regs regs_i (
        .clk, .rst_n, .cfg_req_i, .cfg_rdata_o,
        .job_done_i(job_done), .job_start_o(job_start), .cfg_o(cfg)
    );

    dma_engine dma_i (
        .clk, .rst_n, .cfg_i(cfg), .start_i(job_start), .done_o(job_done),
        .ar_o, .ar_ready_i, .r_i, .r_ready_o,
        .aw_o, .aw_ready_i, .w_o, .w_ready_i, .b_valid_i, .b_ready_o,
        .buf_a_wr_o(buf_a_wr), .buf_b_wr_o(buf_b_wr),
        .mm_start_o(mm_start), .mm_done_i(mm_done), .acc_tile_i(acc_tile)
    );

    // A columns and B rows, same row index k
    tile_buffer buf_a_i (.clk, .wr_i(buf_a_wr), .raddr_i(a_raddr), .rdata_o(a_rdata));
    tile_buffer buf_b_i (.clk, .wr_i(buf_b_wr), .raddr_i(b_raddr), .rdata_o(b_rdata));

    mm_engine mm_i (
        .clk, .rst_n, .start_i(mm_start), .width_i(cfg.width),
        .a_raddr_o(a_raddr), .a_rdata_i(a_rdata),
        .b_raddr_o(b_raddr), .b_rdata_i(b_rdata),
        .done_o(mm_done), .acc_o(acc_tile)
    );

endmodule

//--- dv/axi_mem_model.sv
// testbench memory behind the accelerator's single-beat AXI ports
// 1024 lines of 128 bits, random ready and reply gaps, replies in request order
`include "mm_defs.svh"

module axi_mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  mm_pkg::axi_addr_t ar_i,
    output logic              ar_ready_o,
    output mm_pkg::axi_data_t r_o,
    input  logic              r_ready_i,
    input  mm_pkg::axi_addr_t aw_i,
    output logic              aw_ready_o,
    input  mm_pkg::axi_data_t w_i,
    output logic              w_ready_o,
    output logic              b_valid_o,
    input  logic              b_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // line index is addr[13:4]
    logic [`MM_BUF_DW-1:0] mem [1024];
    int unsigned           wr_cnt = 0;
    logic [`MM_ADDR_W-1:0] rd_q [$];
    logic [`MM_ADDR_W-1:0] aw_q [$];
    logic [`MM_BUF_DW-1:0] w_q [$];
    logic [`MM_ADDR_W-1:0] addr;
    int                    b_pend = 0;
    // beat on the channel goes out at the next rising edge
    logic                  r_go = 1'b0;
    logic                  b_go = 1'b0;

    initial begin
        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        r_o        = '0;
        b_valid_o  = 1'b0;
    end

    // all outputs move on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            ar_ready_o = 1'b0;
            aw_ready_o = 1'b0;
            w_ready_o  = 1'b0;
            r_o        = '0;
            b_valid_o  = 1'b0;
            r_go       = 1'b0;
            b_go       = 1'b0;
            b_pend     = 0;
            rd_q.delete();
            aw_q.delete();
            w_q.delete();
        end else begin
            // retire beats taken at the last rising edge
            if (r_go) r_o.valid = 1'b0;
            if (b_go) b_valid_o = 1'b0;
            // next read reply after a random gap
            if (!r_o.valid && rd_q.size() > 0 && $urandom_range(0, 3) != 0) begin
                addr      = rd_q.pop_front();
                r_o.data  = mem[addr[13:4]];
                r_o.valid = 1'b1;
            end
            if (!b_valid_o && b_pend > 0 && $urandom_range(0, 3) != 0) begin
                b_valid_o = 1'b1;
                b_pend--;
            end
            ar_ready_o = ($urandom_range(0, 2) != 0);
            aw_ready_o = ($urandom_range(0, 2) != 0);
            w_ready_o  = ($urandom_range(0, 2) != 0);
            // DUT side is stable here, so these transfer at the coming edge
            if (ar_i.valid && ar_ready_o) rd_q.push_back(ar_i.addr);
            if (aw_i.valid && aw_ready_o) aw_q.push_back(aw_i.addr);
            if (w_i.valid && w_ready_o) w_q.push_back(w_i.data);
            r_go = r_o.valid && r_ready_i;
            b_go = b_valid_o && b_ready_i;
            // address and data paired up, store and queue a response
            if (aw_q.size() > 0 && w_q.size() > 0) begin
                addr = aw_q.pop_front();
                mem[addr[13:4]] = w_q.pop_front();
                wr_cnt++;
                b_pend++;
            end
        end
    end

endmodule

//--- dv/mm_accel_tb.sv
// testbench of the matrix-multiply accelerator
// random jobs whose results in the memory model are checked against a signed model
`include "mm_defs.svh"

module mm_accel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  rst_n;
    mm_pkg::cfg_req_t      cfg_req;
    logic [31:0]           cfg_rdata;
    mm_pkg::axi_addr_t     ar;
    mm_pkg::axi_addr_t     aw;
    mm_pkg::axi_data_t     r;
    mm_pkg::axi_data_t     w;
    logic                  ar_ready;
    logic                  r_ready;
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic                  b_ready;
    // rows as written to memory with A transposed
    logic [`MM_BUF_DW-1:0] a_rows [64];
    logic [`MM_BUF_DW-1:0] b_rows [64];
    int                    err_cnt = 0;
    int                    test_cnt = 0;
    int                    fail_cnt = 0;
    // set once a job never reports done
    bit                    timed_out = 1'b0;

    mm_accel_top dut_i (
        .clk(clk), .rst_n(rst_n), .cfg_req_i(cfg_req), .cfg_rdata_o(cfg_rdata),
        .ar_o(ar), .ar_ready_i(ar_ready), .r_i(r), .r_ready_o(r_ready),
        .aw_o(aw), .aw_ready_i(aw_ready), .w_o(w), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .b_ready_o(b_ready)
    );

    axi_mem_model mem_i (
        .clk(clk), .rst_n(rst_n), .ar_i(ar), .ar_ready_o(ar_ready), .r_o(r),
        .r_ready_i(r_ready), .aw_i(aw), .aw_ready_o(aw_ready), .w_i(w),
        .w_ready_o(w_ready), .b_valid_o(b_valid), .b_ready_i(b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic write_reg(input mm_pkg::cfg_reg_e idx, input logic [31:0] data);
        @(negedge clk);
        cfg_req = '{wr: 1'b1, idx: idx, wdata: data};
        @(negedge clk);
        cfg_req.wr = 1'b0;
    endtask

    // the read mux is combinational so sample a little after the drive
    task automatic read_reg(input mm_pkg::cfg_reg_e idx, output logic [31:0] data);
        @(negedge clk);
        cfg_req.wr  = 1'b0;
        cfg_req.idx = idx;
        #1;
        data = cfg_rdata;
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_line(input string name, input logic [`MM_BUF_DW-1:0] exp,
                              input logic [`MM_BUF_DW-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: failed", name);
        end
    endtask

    // C row i holds the low 32 bits of the sum over k of A[i][k]*B[k][j]
    function automatic logic [`MM_BUF_DW-1:0] expect_row(input int i, input int k);
        logic [`MM_BUF_DW-1:0] row;
        longint                sum;
        row = '0;
        for (int j = 0; j < `MM_SA_WIDTH; j++) begin
            sum = 0;
            for (int n = 0; n < k; n++) begin
                sum += longint'($signed(a_rows[n][i*`MM_DW +: `MM_DW]))
                     * longint'($signed(b_rows[n][j*`MM_DW +: `MM_DW]));
            end
            row[j*`MM_DW +: `MM_DW] = sum[31:0];
        end
        return row;
    endfunction

    // busy must hold until done shows up
    task automatic wait_done(input string name, input int limit);
        logic [31:0] st;
        int          cycles;
        cycles = 0;
        read_reg(mm_pkg::STATUS, st);
        while (!st[1] && cycles < limit) begin
            check_reg({name, " busy"}, 32'h1, st);
            cycles++;
            read_reg(mm_pkg::STATUS, st);
        end
        if (st[1]) begin
            check_reg({name, " status"}, 32'h2, st);
        end else begin
            $display("timeout waiting for done in %s", name);
            timed_out = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic run_job(input string name, input int k, input bit restart);
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
        logic [31:0] rd;
        int unsigned wr_before;
        int          errs_before;
        // a hung DUT takes no further jobs
        if (timed_out) begin
            return;
        end
        errs_before = err_cnt;
        a_addr = 32'h0000_0000 + ($urandom_range(0, 127) << 4);
        b_addr = 32'h0000_1000 + ($urandom_range(0, 127) << 4);
        c_addr = 32'h0000_2000 + ($urandom_range(0, 60) << 4);
        for (int n = 0; n < k; n++) begin
            a_rows[n] = {$urandom(), $urandom(), $urandom(), $urandom()};
            b_rows[n] = {$urandom(), $urandom(), $urandom(), $urandom()};
            mem_i.mem[10'((a_addr >> 4) + n)] = a_rows[n];
            mem_i.mem[10'((b_addr >> 4) + n)] = b_rows[n];
        end
        // stale C lines carry their own address
        for (int i = 0; i < `MM_SA_WIDTH; i++) begin
            mem_i.mem[10'((c_addr >> 4) + i)] = {4{~(c_addr + 32'(i * 16))}};
        end
        wr_before = mem_i.wr_cnt;
        write_reg(mm_pkg::A_ADDR, a_addr);
        write_reg(mm_pkg::B_ADDR, b_addr);
        write_reg(mm_pkg::C_ADDR, c_addr);
        write_reg(mm_pkg::WIDTH, 32'(k));
        write_reg(mm_pkg::CTRL, 32'h1);
        // second start lands while busy
        if (restart) write_reg(mm_pkg::CTRL, 32'h1);
        read_reg(mm_pkg::STATUS, rd);
        check_reg({name, " status after start"}, 32'h1, rd);
        wait_done(name, 4000);
        if (!timed_out) begin
            check_reg({name, " write beats"}, 32'd4, 32'(mem_i.wr_cnt - wr_before));
            for (int i = 0; i < `MM_SA_WIDTH; i++) begin
                check_line($sformatf("%s row %0d", name, i), expect_row(i, k),
                           mem_i.mem[10'((c_addr >> 4) + i)]);
            end
        end
        report_test(name, errs_before);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] vals [4];
        int          errs_before;
        void'($urandom(10));
        rst_n   = 1'b0;
        cfg_req = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs_before = err_cnt;
        for (int n = 0; n < 6; n++) begin
            read_reg(mm_pkg::cfg_reg_e'(n), rd);
            check_reg($sformatf("reset_values reg %0d", n), 32'h0, rd);
        end
        report_test("reset_values", errs_before);

        errs_before = err_cnt;
        vals[0] = $urandom();
        vals[1] = $urandom();
        vals[2] = $urandom();
        vals[3] = 32'($urandom_range(1, 64));
        for (int n = 0; n < 4; n++) write_reg(mm_pkg::cfg_reg_e'(n), vals[n]);
        for (int n = 0; n < 4; n++) begin
            read_reg(mm_pkg::cfg_reg_e'(n), rd);
            check_reg($sformatf("reg_readback reg %0d", n), vals[n], rd);
        end
        report_test("reg_readback", errs_before);

        run_job("single_k4", 4, 1'b0);
        for (int n = 0; n < 20; n++) begin
            run_job($sformatf("random_job_%0d", n), int'($urandom_range(1, 64)), 1'b0);
        end
        run_job("start_while_busy", int'($urandom_range(8, 32)), 1'b1);
        // long, short, odd K in a row
        run_job("back_to_back_k64", 64, 1'b0);
        run_job("back_to_back_k1", 1, 1'b0);
        run_job("back_to_back_k13", 13, 1'b0);

        $display("tests %0d, failing tests %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/mm_pkg.sv
design/mm_cfg_regs.sv
design/tile_buffer.sv
design/mm_engine.sv
design/dma_engine.sv
design/mm_accel_top.sv
dv/axi_mem_model.sv
dv/mm_accel_tb.sv

//--- run.sh
#!/bin/sh
# build and run the accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module mm_accel_tb -o mm_accel_sim

./obj_dir/mm_accel_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    exit 0
else
    exit 1
fi
